// ==== filelist.f ====
hw/cart_pkg.sv
hw/snes_bus_sampler.sv
hw/rom_map.sv
hw/mcu_rom_arbiter.sv
hw/rom_port.sv
hw/cart_main.sv
tests/tb_clock_gen.sv
tests/tb_cart_main.sv

// ==== hw/cart_main.sv ====
`timescale 1ns/1ns

module cart_main import cart_pkg::*; #(
  parameter int ROM_CYCLE_LEN = 7,
  parameter int DEAD_TIMEOUT  = 96000
) (
  input  logic                  clk2,
  input  logic                  rst_n,
  input  snes_addr_t            rom_mask,
  // SNES bus
  input  snes_addr_t            snes_addr_in,
  input  logic                  snes_read_in,
  input  logic                  snes_romsel_in,
  input  logic                  snes_cpu_clk_in,
  input  byte_t                 snes_data_in,
  output byte_t                 snes_data_out,
  output logic                  snes_data_oe,
  // MCU
  input  logic                  mcu_rrq,
  input  logic                  mcu_wrq,
  input  snes_addr_t            mcu_addr,
  input  byte_t                 mcu_wdata,
  output logic                  mcu_rdy,
  output byte_t                 mcu_rdata,
  // PSRAM
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic                  rom_we,
  output rom_word_t             rom_data_out,
  output logic                  rom_data_oe,
  input  rom_word_t             rom_data_in
);

  snes_addr_t snes_addr;
  logic       snes_read;
  logic       snes_romsel;
  logic       cpu_clk_sync;
  logic       cycle_start;
  logic       cycle_end;
  snes_addr_t mapped_addr;
  logic       rom_hit;
  arb_state_t state;
  snes_addr_t latched_addr;
  byte_t      latched_wdata;
  logic       mcu_hit;

  ////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////

  snes_bus_sampler u_sampler (
    .clk2(clk2), .rst_n(rst_n),
    .snes_addr_in(snes_addr_in), .snes_read_in(snes_read_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in),
    .snes_addr(snes_addr), .snes_read(snes_read), .snes_romsel(snes_romsel),
    .cpu_clk_sync(cpu_clk_sync), .cycle_start(cycle_start), .cycle_end(cycle_end)
  );

  rom_map u_map (
    .snes_addr(snes_addr), .snes_romsel(snes_romsel), .rom_mask(rom_mask),
    .mapped_addr(mapped_addr), .rom_hit(rom_hit)
  );

  ////////////////////////////////////////////////////////////////////////
  // Execute and result
  ////////////////////////////////////////////////////////////////////////

  mcu_rom_arbiter #(
    .ROM_CYCLE_LEN(ROM_CYCLE_LEN),
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) u_arbiter (
    .clk2(clk2), .rst_n(rst_n),
    .cpu_clk_sync(cpu_clk_sync), .cycle_start(cycle_start),
    .cycle_end(cycle_end), .rom_hit(rom_hit),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .mcu_rdy(mcu_rdy), .state(state), .latched_addr(latched_addr),
    .latched_wdata(latched_wdata), .mcu_hit(mcu_hit)
  );

  rom_port u_port (
    .clk2(clk2), .state(state), .mcu_hit(mcu_hit),
    .latched_addr(latched_addr), .latched_wdata(latched_wdata),
    .mapped_addr(mapped_addr), .rom_hit(rom_hit), .snes_read(snes_read),
    .rom_data_in(rom_data_in), .rom_addr(rom_addr), .rom_bhe(rom_bhe),
    .rom_ble(rom_ble), .rom_we(rom_we), .rom_data_out(rom_data_out),
    .rom_data_oe(rom_data_oe), .snes_data_out(snes_data_out),
    .snes_data_oe(snes_data_oe), .mcu_rdata(mcu_rdata)
  );

endmodule

// ==== hw/cart_pkg.sv ====
package cart_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////

  localparam int SNES_ADDR_W = 24;
  localparam int ROM_ADDR_W  = 23; // PSRAM word address

  ////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////

  typedef logic [SNES_ADDR_W-1:0] snes_addr_t;
  typedef logic [15:0]            rom_word_t;
  typedef logic [7:0]             byte_t;

  // MCU access sequencer, one-hot
  typedef enum logic [4:0] {
    ST_IDLE        = 5'b00001,
    ST_MCU_RD_ADDR = 5'b00010,
    ST_MCU_RD_END  = 5'b00100,
    ST_MCU_WR_ADDR = 5'b01000,
    ST_MCU_WR_END  = 5'b10000
  } arb_state_t;

endpackage

// ==== hw/mcu_rom_arbiter.sv ====
`timescale 1ns/1ns

module mcu_rom_arbiter import cart_pkg::*; #(
  parameter int ROM_CYCLE_LEN = 7,
  parameter int DEAD_TIMEOUT  = 96000
) (
  input  logic       clk2,
  input  logic       rst_n,
  input  logic       cpu_clk_sync,
  input  logic       cycle_start,
  input  logic       cycle_end,
  input  logic       rom_hit,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output logic       mcu_rdy,
  output arb_state_t state,
  output snes_addr_t latched_addr,
  output byte_t      latched_wdata,
  output logic       mcu_hit
);

  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 1);
  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);
  localparam logic [DLY_W-1:0] DLY_LOAD   = DLY_W'(ROM_CYCLE_LEN);
  localparam logic [CNT_W-1:0] DEAD_LIMIT = CNT_W'(DEAD_TIMEOUT);

  logic [CNT_W-1:0] dead_cnt;
  logic             dead;
  logic             free_strobe;
  logic             free_slot;
  logic             rd_pend;
  logic             wr_pend;
  logic             in_end;
  logic [DLY_W-1:0] delay;

  ////////////////////////////////////////////////////////////////////////
  // SNES watchdog and bus slots
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
      dead     <= 1'b1;
    end else if (cpu_clk_sync) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
    end else begin
      if (dead_cnt <= DEAD_LIMIT) dead_cnt <= dead_cnt + 1'b1; // Saturates
      if (dead_cnt > DEAD_LIMIT) dead <= 1'b1;
    end
  end

  // Cycle without ROM traffic leaves the bus free
  always_ff @(posedge clk2) begin
    if (!rst_n) free_strobe <= 1'b0;
    else        free_strobe <= cycle_start & ~rom_hit;
  end

  assign free_slot = cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////
  // MCU request latching
  ////////////////////////////////////////////////////////////////////////

  assign in_end = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (in_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (mcu_rrq || mcu_wrq) latched_addr <= mcu_addr;
    if (mcu_wrq) latched_wdata <= mcu_wdata;
  end

  ////////////////////////////////////////////////////////////////////////
  // Access sequencer
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (dead && cpu_clk_sync) begin
      state <= ST_IDLE; // SNES woke up, pending access starts over
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot || dead) begin
            if (rd_pend) begin
              state <= ST_MCU_RD_ADDR;
              delay <= DLY_LOAD;
            end else if (wr_pend) begin
              state <= ST_MCU_WR_ADDR;
              delay <= DLY_LOAD;
            end
          end
        end
        ST_MCU_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_WR_END;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign mcu_hit = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);

  // MCU handshake rules
  assert property (@(posedge clk2) disable iff (!rst_n)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy);
  assert property (@(posedge clk2) disable iff (!rst_n)
    !(mcu_rrq && mcu_wrq));

endmodule

// ==== hw/rom_map.sv ====
`timescale 1ns/1ns

module rom_map import cart_pkg::*; (
  input  snes_addr_t snes_addr,
  input  logic       snes_romsel,
  input  snes_addr_t rom_mask,
  output snes_addr_t mapped_addr,
  output logic       rom_hit
);

  snes_addr_t lorom_addr;

  // ROMSEL is already qualified by the console
  assign rom_hit = ~snes_romsel;

  // LoROM: A15 only selects the upper half of each bank,
  // so banks pack down into contiguous 32K pages
  assign lorom_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]};

  assign mapped_addr = lorom_addr & rom_mask; // Mirror into loaded size

endmodule

// ==== hw/rom_port.sv ====
`timescale 1ns/1ns

module rom_port import cart_pkg::*; (
  input  logic                  clk2,
  input  arb_state_t            state,
  input  logic                  mcu_hit,
  input  snes_addr_t            latched_addr,
  input  byte_t                 latched_wdata,
  input  snes_addr_t            mapped_addr,
  input  logic                  rom_hit,
  input  logic                  snes_read,
  input  rom_word_t             rom_data_in,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic                  rom_we,
  output rom_word_t             rom_data_out,
  output logic                  rom_data_oe,
  output byte_t                 snes_data_out,
  output logic                  snes_data_oe,
  output byte_t                 mcu_rdata
);

  snes_addr_t sel_addr;
  logic       lane_lo;
  logic       wr_active;
  byte_t      lane_byte;

  ////////////////////////////////////////////////////////////////////////
  // Address and byte lanes
  ////////////////////////////////////////////////////////////////////////

  assign sel_addr = mcu_hit ? latched_addr : mapped_addr;
  assign rom_addr = sel_addr[SNES_ADDR_W-1:1];
  assign lane_lo  = sel_addr[0]; // Odd byte lives in the low half

  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  ////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////

  assign wr_active = (state == ST_MCU_WR_ADDR);

  assign rom_we       = ~wr_active;
  assign rom_data_oe  = wr_active;
  assign rom_data_out = lane_lo ? {8'h00, latched_wdata} : {latched_wdata, 8'h00};

  ////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////

  assign lane_byte = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];

  assign snes_data_out = lane_byte;
  assign snes_data_oe  = rom_hit & ~snes_read;

  // Last sample of the ADDR window is the one handed back
  always_ff @(posedge clk2) begin
    if (state == ST_MCU_RD_ADDR) mcu_rdata <= lane_byte;
  end

  // Write address and data held for the whole write pulse
  assert property (@(posedge clk2)
    !rom_we |-> (mcu_hit && $stable(latched_addr) && $stable(latched_wdata)));

endmodule

// ==== hw/snes_bus_sampler.sv ====
`timescale 1ns/1ns

module snes_bus_sampler import cart_pkg::*; (
  input  logic       clk2,
  input  logic       rst_n,
  input  snes_addr_t snes_addr_in,
  input  logic       snes_read_in,
  input  logic       snes_romsel_in,
  input  logic       snes_cpu_clk_in,
  output snes_addr_t snes_addr,
  output logic       snes_read,
  output logic       snes_romsel,
  output logic       cpu_clk_sync,
  output logic       cycle_start,
  output logic       cycle_end
);

  // Filter taps sit at stages 4 and 5, clock edges look back 6 stages
  snes_addr_t  addr_hist [0:5];
  logic [5:0]  read_hist;
  logic [5:0]  romsel_hist;
  logic [6:0]  clk_hist;

  ////////////////////////////////////////////////////////////////////////
  // Oversampling histories
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk2) begin
    addr_hist[0] <= snes_addr_in;
    for (int i = 1; i < 6; i++) begin
      addr_hist[i] <= addr_hist[i-1];
    end
  end

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      read_hist   <= '1; // Strobes idle high
      romsel_hist <= '1;
      clk_hist    <= '0;
    end else begin
      read_hist   <= {read_hist[4:0], snes_read_in};
      romsel_hist <= {romsel_hist[4:0], snes_romsel_in};
      clk_hist    <= {clk_hist[5:0], snes_cpu_clk_in};
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Two-stage agreement
  ////////////////////////////////////////////////////////////////////////

  assign snes_addr   = addr_hist[5] & addr_hist[4];
  assign snes_read   = read_hist[5] & read_hist[4];
  assign snes_romsel = romsel_hist[5] & romsel_hist[4];

  assign cpu_clk_sync = clk_hist[1]; // Two flops deep

  // Clock must be stable five samples before the edge counts
  assign cycle_start = (clk_hist[6:1] == 6'b000001);
  assign cycle_end   = (clk_hist[6:1] == 6'b111110);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f filelist.f --top-module tb_cart_main -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// ==== tests/rom_cases.txt ====
# op addr data expect: 1/2 MCU write/read with SNES clock stopped,
# 3/4 MCU write/read with SNES clock running, 5 SNES ROM read (data unused)
1 000010 5a 00
2 000010 00 5a
2 000011 00 08
1 000021 c3 00
2 000021 00 c3
2 000020 00 10
2 000044 00 22
3 000030 a5 00
4 000030 00 a5
4 000031 00 18
3 000067 3c 00
4 000067 00 3c
5 808010 00 5a
5 808021 00 c3
5 81c031 00 18
5 02fffe 00 ff
5 c0e067 00 3c
2 000010 00 5a

// ==== tests/tb_cart_main.sv ====
`timescale 1ns/1ns

module tb_cart_main;

  localparam int CASE_CYCLES = 600;
  localparam int SNES_HALF   = 8; // CLK2 cycles per CPU clock phase

  logic        clk2;
  logic        rst_n;
  logic [23:0] snes_addr_in;
  logic        snes_read_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  logic [7:0]  snes_data_in;
  logic [7:0]  snes_data_out;
  logic        snes_data_oe;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_wdata;
  logic        mcu_rdy;
  logic [7:0]  mcu_rdata;
  logic [22:0] rom_addr;
  logic        rom_bhe;
  logic        rom_ble;
  logic        rom_we;
  logic [15:0] rom_data_out;
  logic        rom_data_oe;
  logic [15:0] rom_data_in;

  logic [15:0] psram [0:255];
  logic [3:0]  case_op [$];
  logic [23:0] case_addr [$];
  logic [7:0]  case_data [$];
  logic [7:0]  case_exp [$];
  int          n_checks;
  int          n_errors;
  int          cycle_count;
  int          cycle_limit;
  logic        clk_run;
  int          start_phase;
  int          half_cnt;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(10)) u_clk (.clk2(clk2), .rst_n(rst_n));

  cart_main #(.DEAD_TIMEOUT(200)) uut (
    .clk2(clk2), .rst_n(rst_n), .rom_mask(24'h3FFFFF),
    .snes_addr_in(snes_addr_in), .snes_read_in(snes_read_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in),
    .snes_data_in(snes_data_in), .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata),
    .rom_addr(rom_addr), .rom_bhe(rom_bhe), .rom_ble(rom_ble), .rom_we(rom_we),
    .rom_data_out(rom_data_out), .rom_data_oe(rom_data_oe), .rom_data_in(rom_data_in)
  );

  //////////////////////////////////////////////////////////////////////
  // PSRAM model and SNES CPU clock
  //////////////////////////////////////////////////////////////////////

  initial begin
    for (int i = 0; i < 256; i++) psram[i] = {i[7:0], i[7:0]};
  end

  assign rom_data_in = psram[rom_addr[7:0]];

  always @(posedge clk2) begin
    if (!rom_we) begin
      if (!rom_bhe) psram[rom_addr[7:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) psram[rom_addr[7:0]][7:0] <= rom_data_out[7:0];
    end
  end

  initial begin
    snes_cpu_clk_in = 1'b0;
    half_cnt = 0;
    forever begin
      @(negedge clk2);
      if (!clk_run) begin
        snes_cpu_clk_in = 1'b0; // Held low, SNES goes dead
        half_cnt = start_phase;
      end else if (half_cnt == 0) begin
        snes_cpu_clk_in = !snes_cpu_clk_in;
        half_cnt = SNES_HALF - 1;
      end else begin
        half_cnt--;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk2);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error: %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic set_snes_clock(input logic on);
    if (on && !clk_run) start_phase = int'($urandom % 8); // Random bus phase
    clk_run = on;
  endtask

  task automatic mcu_access(input logic is_write, input logic [23:0] addr,
                            input logic [7:0] data, input string name);
    int wr_cycles;
    wr_cycles = 0;
    while (!mcu_rdy) @(negedge clk2);
    mcu_addr  = addr;
    mcu_wdata = data;
    mcu_wrq   = is_write;
    mcu_rrq   = !is_write;
    @(negedge clk2);
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    while (!mcu_rdy) begin
      if (!rom_we) begin
        wr_cycles++;
        compare_value({name, " rom_addr"}, 32'(addr[23:1]), 32'(rom_addr));
        compare_value({name, " rom_bhe"}, 32'(addr[0]), 32'(rom_bhe));
        compare_value({name, " rom_ble"}, 32'(!addr[0]), 32'(rom_ble));
        compare_value({name, " rom_data_oe"}, 32'd1, 32'(rom_data_oe));
        compare_value({name, " rom_data_out"}, 32'(data),
                      32'(addr[0] ? rom_data_out[7:0] : rom_data_out[15:8]));
      end
      @(negedge clk2);
    end
    if (is_write && wr_cycles == 0) begin
      $display("%s: the MCU write never reached the PSRAM", name);
      n_errors++;
    end
    if (!is_write && wr_cycles != 0) begin
      $display("%s: the PSRAM was written during an MCU read", name);
      n_errors++;
    end
  endtask

  task automatic snes_rom_read(input logic [23:0] addr, input logic [7:0] exp,
                               input string name);
    logic [22:0] exp_word;
    exp_word = 23'({addr[22:16], addr[14:1]}); // LoROM fold, A15 dropped
    snes_addr_in   = addr;
    snes_romsel_in = 1'b0;
    snes_read_in   = 1'b0;
    while (!snes_data_oe) @(negedge clk2);
    repeat (2) @(negedge clk2); // Address filter settles
    compare_value({name, " snes_data_out"}, 32'(exp), 32'(snes_data_out));
    compare_value({name, " rom_addr"}, 32'(exp_word), 32'(rom_addr));
    compare_value({name, " rom_bhe"}, 32'(addr[0]), 32'(rom_bhe));
    compare_value({name, " rom_ble"}, 32'(!addr[0]), 32'(rom_ble));
    snes_romsel_in = 1'b1;
    snes_read_in   = 1'b1;
    while (snes_data_oe) @(negedge clk2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    string       line;
    string       name;
    logic [3:0]  op;
    logic [23:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
    mcu_rrq        = 1'b0;
    mcu_wrq        = 1'b0;
    mcu_addr       = '0;
    mcu_wdata      = '0;
    snes_addr_in   = '0;
    snes_read_in   = 1'b1;
    snes_romsel_in = 1'b1;
    snes_data_in   = '0;
    clk_run        = 1'b0;
    start_phase    = 0;
    n_checks       = 0;
    n_errors       = 0;
    cycle_limit    = 0;
    void'($urandom(56952));

    fd = $fopen("tests/rom_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/rom_cases.txt");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h", op, addr, data, exp) == 4) begin
            case_op.push_back(op);
            case_addr.push_back(addr);
            case_data.push_back(data);
            case_exp.push_back(exp);
          end
        end
      end
      $fclose(fd);
    end
    if (case_op.size() == 0) begin
      $display("No test cases were loaded");
      n_errors++;
    end
    cycle_limit = CASE_CYCLES * (case_op.size() + 1);

    while (!rst_n) @(negedge clk2);
    @(negedge clk2);
    compare_value("reset mcu_rdy", 32'd1, 32'(mcu_rdy));
    compare_value("reset rom_we", 32'd1, 32'(rom_we));
    compare_value("reset rom_data_oe", 32'd0, 32'(rom_data_oe));
    compare_value("reset snes_data_oe", 32'd0, 32'(snes_data_oe));

    foreach (case_op[i]) begin
      name = $sformatf("case %0d addr %06h", i, case_addr[i]);
      case (case_op[i])
        4'h1, 4'h3: begin
          set_snes_clock(case_op[i] == 4'h3);
          mcu_access(1'b1, case_addr[i], case_data[i], name);
        end
        4'h2, 4'h4: begin
          set_snes_clock(case_op[i] == 4'h4);
          mcu_access(1'b0, case_addr[i], case_data[i], name);
          compare_value({name, " mcu_rdata"}, 32'(case_exp[i]), 32'(mcu_rdata));
        end
        4'h5: begin
          set_snes_clock(1'b1);
          snes_rom_read(case_addr[i], case_exp[i], name);
        end
        default: begin
          $display("Unknown operation %0h in case %0d", case_op[i], i);
          n_errors++;
        end
      endcase
    end

    $display("Checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk2,
  output logic rst_n
);

  initial begin
    clk2 = 1'b0;
    forever #(PERIOD / 2) clk2 = ~clk2;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk2); // Released away from the sampling edge
    rst_n = 1'b1;
  end

endmodule
